/* verilog/raster_pkg.sv */
package raster_pkg;

    // Screen size in pixels
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;

    // Serial reciprocal divider
    localparam int DIV_STEPS = 17;  // Quotient bits of 2^16 / d
    localparam int DIV_CNT_W = 5;
    localparam int RECIP_W = 16;
    localparam logic [DIV_STEPS-1:0] DIV_DIVIDEND = 17'h1_0000;
    localparam logic [RECIP_W-1:0] RECIP_SAT = 16'hFFFF;  // Zero divisor

    typedef struct packed {
        logic signed [31:0] x;  // Q16.16
        logic signed [31:0] y;
        logic signed [31:0] z;
    } pos_t;

    typedef struct packed {
        pos_t pos;
        logic [23:0] color;
    } vertex_t;

    typedef struct packed {
        logic signed [18:0] v0x;  // Q16.3
        logic signed [18:0] v0y;
        logic signed [18:0] e0x;
        logic signed [18:0] e0y;
        logic signed [18:0] e1x;
        logic signed [18:0] e1y;
        logic signed [37:0] d00;  // Q32.6
        logic signed [37:0] d01;
        logic signed [37:0] d11;
        logic [23:0] v0_color;
        logic [23:0] v1_color;
        logic [23:0] v2_color;
        logic [31:0] v0_depth;
        logic [31:0] v1_depth;
        logic [31:0] v2_depth;
    } geom_t;

    typedef struct packed {
        logic [15:0] bbox_min_x;
        logic [15:0] bbox_max_x;
        logic [15:0] bbox_min_y;
        logic [15:0] bbox_max_y;
    } bbox_t;

    typedef struct packed {
        logic signed [18:0] v0x;
        logic signed [18:0] v0y;
        logic signed [18:0] e0x;
        logic signed [18:0] e0y;
        logic signed [18:0] e1x;
        logic signed [18:0] e1y;
        logic signed [37:0] d00;
        logic signed [37:0] d01;
        logic signed [37:0] d11;
        logic [23:0] v0_color;
        logic [23:0] v1_color;
        logic [23:0] v2_color;
        logic [31:0] v0_depth;
        logic [31:0] v1_depth;
        logic [31:0] v2_depth;
        logic [15:0] bbox_min_x;
        logic [15:0] bbox_max_x;
        logic [15:0] bbox_min_y;
        logic [15:0] bbox_max_y;
        logic [15:0] denom_inv;  // Q0.16
        logic denom_neg;
    } triangle_state_t;

    function automatic logic signed [31:0] min3(
        input logic signed [31:0] a,
        input logic signed [31:0] b,
        input logic signed [31:0] c
    );
        logic signed [31:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic signed [31:0] max3(
        input logic signed [31:0] a,
        input logic signed [31:0] b,
        input logic signed [31:0] c
    );
        logic signed [31:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    function automatic logic signed [31:0] clamp(
        input logic signed [31:0] v,
        input logic signed [31:0] lo,
        input logic signed [31:0] hi
    );
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

endpackage

/* verilog/setup_fsm.sv */
`timescale 1ns/10ps

module setup_fsm (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_ready,
    input  logic div_done,
    output logic in_ready,
    output logic capture,
    output logic div_start,
    output logic out_valid,
    output logic busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_wait,
        st_output
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (in_valid) begin
                    state_next = st_start;
                end
            end
            st_start: begin
                state_next = st_wait;  // Divider loads here
            end
            st_wait: begin
                if (div_done) begin
                    state_next = st_output;
                end
            end
            st_output: begin
                // Hold record until the consumer takes it
                if (out_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    assign in_ready = (state == st_idle);
    assign capture = in_ready && in_valid;  // Accepting edge
    assign div_start = (state == st_start);
    assign out_valid = (state == st_output);
    assign busy = (state != st_idle);

endmodule

/* verilog/div_step_counter.sv */
`timescale 1ns/10ps

module div_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic div_start,
    output logic div_step,
    output logic div_done
);

    logic [raster_pkg::DIV_CNT_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (div_start) begin
            count <= raster_pkg::DIV_CNT_W'(raster_pkg::DIV_STEPS);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // One quotient bit per nonzero count
    assign div_step = (count != '0);
    assign div_done = (count == raster_pkg::DIV_CNT_W'(1));  // Last step

endmodule

/* verilog/edge_geometry.sv */
`timescale 1ns/10ps

module edge_geometry (
    input  logic clk,
    input  logic rst,
    input  logic capture,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    output raster_pkg::geom_t geom,
    output logic [63:0] div_divisor,
    output logic denom_neg
);

    logic signed [18:0] v0x, v0y, v1x, v1y, v2x, v2y;
    logic signed [18:0] e0x, e0y, e1x, e1y;
    logic signed [37:0] d00, d01, d11;
    logic signed [75:0] denom;  // Q64.12
    logic [75:0] denom_abs;
    raster_pkg::geom_t geom_next;

    // Q16.16 down to Q16.3
    assign v0x = v0.pos.x[31:13];
    assign v0y = v0.pos.y[31:13];
    assign v1x = v1.pos.x[31:13];
    assign v1y = v1.pos.y[31:13];
    assign v2x = v2.pos.x[31:13];
    assign v2y = v2.pos.y[31:13];

    assign e0x = v1x - v0x;
    assign e0y = v1y - v0y;
    assign e1x = v2x - v0x;
    assign e1y = v2y - v0y;

    assign d00 = e0x * e0x + e0y * e0y;
    assign d01 = e0x * e1x + e0y * e1y;
    assign d11 = e1x * e1x + e1y * e1y;

    assign denom = d00 * d11 - d01 * d01;
    assign denom_abs = denom[75] ? -denom : denom;

    always_comb begin
        geom_next = '{
            v0x: v0x, v0y: v0y,
            e0x: e0x, e0y: e0y,
            e1x: e1x, e1y: e1y,
            d00: d00, d01: d01, d11: d11,
            v0_color: v0.color, v1_color: v1.color, v2_color: v2.color,
            v0_depth: v0.pos.z, v1_depth: v1.pos.z, v2_depth: v2.pos.z
        };
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            geom <= '0;
            div_divisor <= '0;
            denom_neg <= 1'b0;
        end else if (capture) begin
            geom <= geom_next;
            div_divisor <= denom_abs[75:12];  // Integer part only
            denom_neg <= denom[75];
        end
    end

endmodule

/* verilog/bbox_clamp.sv */
`timescale 1ns/10ps

module bbox_clamp (
    input  logic clk,
    input  logic rst,
    input  logic capture,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    output raster_pkg::bbox_t bbox
);

    localparam logic signed [31:0] CEIL_ADD = 32'sh0000_FFFF;

    logic signed [31:0] min_x, max_x, min_y, max_y;
    raster_pkg::bbox_t bbox_next;

    // Floor of the minimum, ceiling of the maximum
    assign min_x = raster_pkg::min3(v0.pos.x, v1.pos.x, v2.pos.x) >>> 16;
    assign min_y = raster_pkg::min3(v0.pos.y, v1.pos.y, v2.pos.y) >>> 16;
    assign max_x = (raster_pkg::max3(v0.pos.x, v1.pos.x, v2.pos.x) + CEIL_ADD) >>> 16;
    assign max_y = (raster_pkg::max3(v0.pos.y, v1.pos.y, v2.pos.y) + CEIL_ADD) >>> 16;

    always_comb begin
        bbox_next.bbox_min_x = 16'(raster_pkg::clamp(min_x, 0, raster_pkg::SCREEN_W - 1));
        bbox_next.bbox_max_x = 16'(raster_pkg::clamp(max_x, 0, raster_pkg::SCREEN_W - 1));
        bbox_next.bbox_min_y = 16'(raster_pkg::clamp(min_y, 0, raster_pkg::SCREEN_H - 1));
        bbox_next.bbox_max_y = 16'(raster_pkg::clamp(max_y, 0, raster_pkg::SCREEN_H - 1));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bbox <= '0;
        end else if (capture) begin
            bbox <= bbox_next;
        end
    end

endmodule

/* verilog/recip_divider.sv */
`timescale 1ns/10ps

module recip_divider (
    input  logic clk,
    input  logic rst,
    input  logic div_start,
    input  logic div_step,
    input  logic div_done,
    input  logic [63:0] div_divisor,
    output logic [15:0] denom_inv
);

    localparam int N = raster_pkg::DIV_STEPS;

    logic [63:0] rem;
    logic [64:0] rem_shift;  // Partial remainder
    logic [64:0] rem_next;
    logic q_bit;
    logic [N-1:0] dq;  // Dividend bits out at the top, quotient bits in at the bottom
    logic [N-1:0] dq_next;

    assign rem_shift = {rem, dq[N-1]};
    assign q_bit = (rem_shift >= {1'b0, div_divisor});
    assign rem_next = q_bit ? (rem_shift - {1'b0, div_divisor}) : rem_shift;
    assign dq_next = {dq[N-2:0], q_bit};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem <= '0;
            dq <= '0;
        end else if (div_start) begin
            rem <= '0;
            dq <= raster_pkg::DIV_DIVIDEND;
        end else if (div_step) begin
            rem <= rem_next[63:0];  // Always below the divisor
            dq <= dq_next;
        end
    end

    // Final quotient bit is folded in on the done edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            denom_inv <= '0;
        end else if (div_done) begin
            if (div_divisor == '0) begin
                denom_inv <= raster_pkg::RECIP_SAT;
            end else begin
                denom_inv <= dq_next[raster_pkg::RECIP_W-1:0];
            end
        end
    end

endmodule

/* verilog/triangle_setup.sv */
`timescale 1ns/10ps

module triangle_setup (
    input  logic clk,
    input  logic rst,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    input  logic in_valid,
    output logic in_ready,
    output raster_pkg::triangle_state_t out_state,
    output logic out_valid,
    input  logic out_ready,
    output logic busy
);

    logic capture;
    logic div_start;
    logic div_step;
    logic div_done;
    logic [63:0] div_divisor;
    logic denom_neg;
    logic [15:0] denom_inv;
    raster_pkg::geom_t geom;
    raster_pkg::bbox_t bbox;

    setup_fsm fsm0 (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .out_ready(out_ready),
        .div_done(div_done),
        .in_ready(in_ready),
        .capture(capture),
        .div_start(div_start),
        .out_valid(out_valid),
        .busy(busy)
    );

    div_step_counter cnt0 (
        .clk(clk),
        .rst(rst),
        .div_start(div_start),
        .div_step(div_step),
        .div_done(div_done)
    );

    edge_geometry geo0 (
        .clk(clk),
        .rst(rst),
        .capture(capture),
        .v0(v0),
        .v1(v1),
        .v2(v2),
        .geom(geom),
        .div_divisor(div_divisor),
        .denom_neg(denom_neg)
    );

    bbox_clamp box0 (
        .clk(clk),
        .rst(rst),
        .capture(capture),
        .v0(v0),
        .v1(v1),
        .v2(v2),
        .bbox(bbox)
    );

    recip_divider div0 (
        .clk(clk),
        .rst(rst),
        .div_start(div_start),
        .div_step(div_step),
        .div_done(div_done),
        .div_divisor(div_divisor),
        .denom_inv(denom_inv)
    );

    // Output record, field order as in triangle_state_t
    assign out_state = {geom, bbox, denom_inv, denom_neg};

endmodule

/* verif/triangle_setup_assert.sv */
`timescale 1ns/10ps

module triangle_setup_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_ready,
    input raster_pkg::triangle_state_t out_state,
    input logic out_valid,
    input logic out_ready,
    input logic busy
);

    localparam int LATENCY = raster_pkg::DIV_STEPS + 1;

    // Record frozen under back-pressure
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(out_state))
        else $error("out_state changed while out_ready was low");

    // Busy with in_ready low until the output handshake
    busy_until_taken: assert property (@(posedge clk) disable iff (rst)
        (busy && !(out_valid && out_ready)) |=> (busy && !in_ready))
        else $error("busy dropped or in_ready rose before the output handshake");

    // Low through the divider run, then high
    fixed_latency: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_ready) |=> !out_valid [*LATENCY] ##1 out_valid)
        else $error("out_valid did not rise at the fixed latency");

    ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else $error("in_ready low in the first cycle after reset");

endmodule

bind triangle_setup triangle_setup_assert chk0 (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_state(out_state),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .busy(busy)
);

/* verif/triangle_setup_tb.sv */
`timescale 1ns/10ps

module triangle_setup_tb;

    localparam int NUM_TRI = 300;
    localparam int LATENCY = raster_pkg::DIV_STEPS + 1;
    localparam int WAIT_LIMIT = 64;

    logic clk;
    logic rst;
    raster_pkg::vertex_t v0;
    raster_pkg::vertex_t v1;
    raster_pkg::vertex_t v2;
    logic in_valid;
    logic in_ready;
    raster_pkg::triangle_state_t out_state;
    logic out_valid;
    logic out_ready;
    logic busy;
    integer seed;
    raster_pkg::triangle_state_t expected;

    triangle_setup dut0 (
        .clk(clk),
        .rst(rst),
        .v0(v0),
        .v1(v1),
        .v2(v2),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_state(out_state),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_state(input string name, input raster_pkg::triangle_state_t got,
                               input raster_pkg::triangle_state_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idle();
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Whole pixel plus random Q16.16 fraction
    function automatic logic signed [31:0] random_coord(input int lo_pix, input int span);
        int pix;
        pix = lo_pix + rand_below(span);
        return pix * 65536 + rand_below(65536);
    endfunction

    // Within 8 pixels, so the divisor lands in the 16-bit range
    function automatic logic signed [31:0] near_coord(input logic signed [31:0] base);
        int steps;
        steps = rand_below(128) - 64;
        return base + steps * 8192 + rand_below(8192);
    endfunction

    task automatic make_triangle(output raster_pkg::vertex_t a, b, c);
        int kind;
        kind = rand_below(8);
        a.pos.x = random_coord(-48, 416);
        a.pos.y = random_coord(-48, 336);
        a.pos.z = $random(seed);
        a.color = 24'($random(seed));
        b = a;
        c = a;  // Kind 0 stays degenerate
        if (kind != 0) begin
            b.pos.z = $random(seed);
            c.pos.z = $random(seed);
            b.color = 24'($random(seed));
            c.color = 24'($random(seed));
        end
        if (kind == 1 || kind == 2) begin
            b.pos.x = near_coord(a.pos.x);
            b.pos.y = near_coord(a.pos.y);
            c.pos.x = near_coord(a.pos.x);
            c.pos.y = near_coord(a.pos.y);
        end else if (kind > 2) begin
            b.pos.x = random_coord(-48, 416);
            b.pos.y = random_coord(-48, 336);
            c.pos.x = random_coord(-48, 416);
            c.pos.y = random_coord(-48, 336);
        end
    endtask

    function automatic raster_pkg::triangle_state_t model_setup(
        input raster_pkg::vertex_t a, input raster_pkg::vertex_t b, input raster_pkg::vertex_t c
    );
        raster_pkg::triangle_state_t s;
        logic signed [18:0] ax, ay, bx, by, cx, cy;
        logic signed [75:0] e0x, e0y, e1x, e1y, d00, d01, d11, denom, mag;
        logic [63:0] divisor;
        logic [64:0] quot;
        logic signed [31:0] lo_x, hi_x, lo_y, hi_y;
        ax = a.pos.x >>> 13;  // Q16.3
        ay = a.pos.y >>> 13;
        bx = b.pos.x >>> 13;
        by = b.pos.y >>> 13;
        cx = c.pos.x >>> 13;
        cy = c.pos.y >>> 13;
        e0x = bx - ax;
        e0y = by - ay;
        e1x = cx - ax;
        e1y = cy - ay;
        d00 = e0x * e0x + e0y * e0y;
        d01 = e0x * e1x + e0y * e1y;
        d11 = e1x * e1x + e1y * e1y;
        denom = d00 * d11 - d01 * d01;
        mag = (denom < 0) ? -denom : denom;
        divisor = mag[75:12];
        quot = 65'h1_0000 / {1'b0, divisor};
        s.v0x = ax;
        s.v0y = ay;
        s.e0x = e0x[18:0];
        s.e0y = e0y[18:0];
        s.e1x = e1x[18:0];
        s.e1y = e1y[18:0];
        s.d00 = d00[37:0];
        s.d01 = d01[37:0];
        s.d11 = d11[37:0];
        s.v0_color = a.color;
        s.v1_color = b.color;
        s.v2_color = c.color;
        s.v0_depth = a.pos.z;
        s.v1_depth = b.pos.z;
        s.v2_depth = c.pos.z;
        lo_x = raster_pkg::min3(a.pos.x, b.pos.x, c.pos.x) >>> 16;
        lo_y = raster_pkg::min3(a.pos.y, b.pos.y, c.pos.y) >>> 16;
        hi_x = (raster_pkg::max3(a.pos.x, b.pos.x, c.pos.x) + 32'sd65535) >>> 16;
        hi_y = (raster_pkg::max3(a.pos.y, b.pos.y, c.pos.y) + 32'sd65535) >>> 16;
        s.bbox_min_x = 16'(raster_pkg::clamp(lo_x, 0, raster_pkg::SCREEN_W - 1));
        s.bbox_max_x = 16'(raster_pkg::clamp(hi_x, 0, raster_pkg::SCREEN_W - 1));
        s.bbox_min_y = 16'(raster_pkg::clamp(lo_y, 0, raster_pkg::SCREEN_H - 1));
        s.bbox_max_y = 16'(raster_pkg::clamp(hi_y, 0, raster_pkg::SCREEN_H - 1));
        s.denom_inv = (divisor == '0) ? 16'hFFFF : quot[15:0];
        s.denom_neg = (denom < 0);
        return s;
    endfunction

    task automatic run_triangle();
        raster_pkg::vertex_t a, b, c;
        int edges;
        int holds;
        make_triangle(a, b, c);
        expected = model_setup(a, b, c);
        edges = 0;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            edges++;
            if (edges > WAIT_LIMIT) abort_run("timeout waiting for in_ready to rise");
        end
        v0 = a;
        v1 = b;
        v2 = c;
        in_valid = 1'b1;
        @(posedge clk);  // Accepting edge
        #1;
        in_valid = 1'b0;
        v0 = ~a;  // Scramble inputs after capture
        v1 = ~b;
        v2 = ~c;
        edges = 0;
        while (!out_valid) begin
            check_flag("busy", busy, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            @(posedge clk);
            #1;
            edges++;
            if (edges > WAIT_LIMIT) abort_run("timeout waiting for out_valid to rise");
        end
        if (edges != LATENCY) begin
            abort_run($sformatf("out_valid rose %0d edges after acceptance instead of %0d",
                                edges, LATENCY));
        end
        check_state("out_state", out_state, expected);
        holds = rand_below(4);
        repeat (holds) begin
            @(posedge clk);
            #1;
            check_flag("out_valid", out_valid, 1'b1);
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("busy", busy, 1'b1);
            check_state("out_state", out_state, expected);
        end
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        check_idle();
    endtask

    task automatic reset_mid_division();
        raster_pkg::vertex_t a, b, c;
        make_triangle(a, b, c);
        v0 = a;
        v1 = b;
        v2 = c;
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        check_flag("busy", busy, 1'b1);
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        check_idle();
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle();
    endtask

    initial begin
        seed = 32'h3539_d672;
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        v0 = '0;
        v1 = '0;
        v2 = '0;
        repeat (4) @(posedge clk);
        #1;
        check_idle();
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle();
        repeat (NUM_TRI) run_triangle();
        reset_mid_division();
        repeat (4) run_triangle();  // Recovery after the reset
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* rasterizer_setup.f */
verilog/raster_pkg.sv
verilog/setup_fsm.sv
verilog/div_step_counter.sv
verilog/edge_geometry.sv
verilog/bbox_clamp.sv
verilog/recip_divider.sv
verilog/triangle_setup.sv
verif/triangle_setup_assert.sv
verif/triangle_setup_tb.sv

/* Bender.yml */
package:
  name: rasterizer_setup

sources:
  - verilog/raster_pkg.sv
  - verilog/setup_fsm.sv
  - verilog/div_step_counter.sv
  - verilog/edge_geometry.sv
  - verilog/bbox_clamp.sv
  - verilog/recip_divider.sv
  - verilog/triangle_setup.sv
  - target: test
    files:
      - verif/triangle_setup_assert.sv
      - verif/triangle_setup_tb.sv
